// File: design/uart_pkg.sv
package uart_pkg;

	//////////////////////////////////////////////////
	// character framing
	//////////////////////////////////////////////////
	localparam int DATA_BITS     = 8;
	localparam int OVERSAMPLE    = 16;
	// one oversample tick every CLKS_PER_TICK clocks, so a bit is 32 clocks
	localparam int CLKS_PER_TICK = 2;

	localparam int TICK_DIV_BITS = $clog2(CLKS_PER_TICK);
	localparam int OS_CNT_BITS   = $clog2(OVERSAMPLE);
	localparam int BIT_CNT_BITS  = $clog2(DATA_BITS);

	// terminal counts
	localparam logic [TICK_DIV_BITS-1:0] TICK_LAST = TICK_DIV_BITS'(CLKS_PER_TICK - 1);
	localparam logic [OS_CNT_BITS-1:0]   OS_LAST   = OS_CNT_BITS'(OVERSAMPLE - 1);
	localparam logic [OS_CNT_BITS-1:0]   OS_MID    = OS_CNT_BITS'(OVERSAMPLE / 2 - 1);
	localparam logic [BIT_CNT_BITS-1:0]  BIT_LAST  = BIT_CNT_BITS'(DATA_BITS - 1);

	//////////////////////////////////////////////////
	// byte FIFO
	//////////////////////////////////////////////////
	localparam int FIFO_ADDR_BITS = 3;
	localparam int FIFO_DEPTH     = 1 << FIFO_ADDR_BITS;

	// receiver states
	localparam logic [2:0] RX_IDLE  = 3'd0;
	localparam logic [2:0] RX_START = 3'd1;
	localparam logic [2:0] RX_DATA  = 3'd2;
	localparam logic [2:0] RX_STOP  = 3'd3;
	localparam logic [2:0] RX_FLUSH = 3'd4;

	// transmitter states
	localparam logic [2:0] TX_IDLE  = 3'd0;
	localparam logic [2:0] TX_LOAD  = 3'd1;
	localparam logic [2:0] TX_START = 3'd2;
	localparam logic [2:0] TX_DATA  = 3'd3;
	localparam logic [2:0] TX_STOP  = 3'd4;

	// controller states
	localparam logic [1:0] CTL_IDLE  = 2'd0;
	localparam logic [1:0] CTL_FETCH = 2'd1;
	localparam logic [1:0] CTL_HOLD  = 2'd2;

endpackage

// File: design/baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen
	import uart_pkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic tick
);

	// free-running divider, wraps at CLKS_PER_TICK
	logic [TICK_DIV_BITS-1:0] div_cnt;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end
		else if (div_cnt == TICK_LAST)
		begin
			// wrap, one-cycle tick
			div_cnt <= '0;
			tick    <= 1'b1;
		end
		else
		begin
			div_cnt <= div_cnt + 1'b1;
			tick    <= 1'b0;
		end
	end

endmodule

// File: design/uart_receiver.sv
`timescale 1ns/1ps

module uart_receiver
	import uart_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tick,
	input  logic                 rxd,
	output logic [DATA_BITS-1:0] rx_byte,
	output logic                 rx_valid,
	output logic                 frame_err
);

	logic                    rx_meta;
	logic                    rx_sync;
	logic [2:0]              state;
	logic [OS_CNT_BITS-1:0]  tick_cnt;
	logic [BIT_CNT_BITS-1:0] bit_cnt;
	logic [DATA_BITS-1:0]    shreg;

	// two-flop sync, idle line is high
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
		end
	end

	//////////////////////////////////////////////////
	// frame FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state     <= RX_IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			rx_valid  <= 1'b0;
			frame_err <= 1'b0;
		end
		else
		begin
			// strobes default low
			rx_valid  <= 1'b0;
			frame_err <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					// falling edge, possible start bit
					if (!rx_sync)
					begin
						tick_cnt <= '0;
						state    <= RX_START;
					end
				end
				RX_START:
				begin
					if (tick)
					begin
						if (tick_cnt == OS_MID)
						begin
							// still low at mid-point, else a glitch
							tick_cnt <= '0;
							bit_cnt  <= '0;
							state    <= rx_sync ? RX_IDLE : RX_DATA;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				RX_DATA:
				begin
					if (tick)
					begin
						if (tick_cnt == OS_LAST)
						begin
							tick_cnt <= '0;
							bit_cnt  <= bit_cnt + 1'b1;
							if (bit_cnt == BIT_LAST)
								state <= RX_STOP;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				RX_STOP:
				begin
					if (tick)
					begin
						if (tick_cnt == OS_LAST)
						begin
							// mid stop bit
							tick_cnt  <= '0;
							rx_valid  <= rx_sync;
							frame_err <= !rx_sync;
							state     <= rx_sync ? RX_IDLE : RX_FLUSH;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				RX_FLUSH:
				begin
					// bad stop bit, line still low
					// ride out the rest of the bit so a following start lines up
					if (tick)
					begin
						if (tick_cnt == OS_MID)
							state <= RX_IDLE;
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// lsb first, shift in from the top
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && tick && tick_cnt == OS_LAST)
			shreg <= {rx_sync, shreg[DATA_BITS-1:1]};
	end

	assign rx_byte = shreg;

endmodule

// File: design/uart_transmitter.sv
`timescale 1ns/1ps

module uart_transmitter
	import uart_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tick,
	input  logic                 cts_n,
	input  logic                 fifo_empty,
	input  logic [DATA_BITS-1:0] fifo_data,
	output logic                 fifo_rd,
	output logic                 txd
);

	logic [2:0]              state;
	logic [OS_CNT_BITS-1:0]  tick_cnt;
	logic [BIT_CNT_BITS-1:0] bit_cnt;
	logic [DATA_BITS-1:0]    shreg;

	// pull a byte only between characters and with cts asserted
	assign fifo_rd = (state == TX_IDLE) && !fifo_empty && !cts_n;

	//////////////////////////////////////////////////
	// serializer FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			txd      <= 1'b1;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					if (fifo_rd)
						state <= TX_LOAD;
				end
				TX_LOAD:
				begin
					// fifo data valid now, start bit goes out
					tick_cnt <= '0;
					txd      <= 1'b0;
					state    <= TX_START;
				end
				TX_START:
				begin
					if (tick)
					begin
						if (tick_cnt == OS_LAST)
						begin
							tick_cnt <= '0;
							bit_cnt  <= '0;
							txd      <= shreg[0];
							state    <= TX_DATA;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				TX_DATA:
				begin
					if (tick)
					begin
						if (tick_cnt == OS_LAST)
						begin
							tick_cnt <= '0;
							bit_cnt  <= bit_cnt + 1'b1;
							// last data bit done, stop bit is high
							if (bit_cnt == BIT_LAST)
							begin
								txd   <= 1'b1;
								state <= TX_STOP;
							end
							else
								txd <= shreg[1];
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				TX_STOP:
				begin
					// cts is not looked at until back in idle
					if (tick)
					begin
						if (tick_cnt == OS_LAST)
							state <= TX_IDLE;
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

	// load on TX_LOAD, shift right after each data bit
	always_ff @(posedge clk)
	begin
		if (state == TX_LOAD)
			shreg <= fifo_data;
		else if (state == TX_DATA && tick && tick_cnt == OS_LAST)
			shreg <= shreg >> 1;
	end

endmodule

// File: design/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo
	import uart_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wr,
	input  logic [DATA_BITS-1:0] wr_data,
	input  logic                 rd,
	output logic [DATA_BITS-1:0] rd_data,
	output logic                 empty,
	output logic                 full
);

	logic [DATA_BITS-1:0]    mem [0:FIFO_DEPTH-1];
	// one extra bit tells full from empty
	logic [FIFO_ADDR_BITS:0] wr_ptr;
	logic [FIFO_ADDR_BITS:0] rd_ptr;
	logic                    do_wr;
	logic                    do_rd;

	// write when full and read when empty are dropped
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS])
		&& (wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0]);

	// pointers
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// storage, read data valid the cycle after rd
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= wr_data;
		if (do_rd)
			rd_data <= mem[rd_ptr[FIFO_ADDR_BITS-1:0]];
	end

endmodule

// File: design/echo_controller.sv
`timescale 1ns/1ps

module echo_controller
	import uart_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rx_empty,
	input  logic                 rx_full,
	input  logic                 rx_valid,
	input  logic [DATA_BITS-1:0] rx_data,
	input  logic                 tx_full,
	output logic                 rx_rd,
	output logic                 tx_wr,
	output logic [DATA_BITS-1:0] tx_data,
	output logic                 overrun
);

	logic [1:0] state;

	// hold state writes as soon as the tx fifo has room
	assign tx_wr = (state == CTL_HOLD) && !tx_full;

	//////////////////////////////////////////////////
	// idle -> fetch -> hold
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= CTL_IDLE;
			rx_rd <= 1'b0;
		end
		else
		begin
			case (state)
				CTL_IDLE:
				begin
					// byte waiting, read pulse next cycle
					if (!rx_empty)
					begin
						rx_rd <= 1'b1;
						state <= CTL_FETCH;
					end
				end
				CTL_FETCH:
				begin
					// first cycle carries rd, second one sees the data
					rx_rd <= 1'b0;
					if (!rx_rd)
						state <= CTL_HOLD;
				end
				CTL_HOLD:
				begin
					// byte held here while tx fifo is full
					if (tx_wr)
						state <= CTL_IDLE;
				end
				default:
					state <= CTL_IDLE;
			endcase
		end
	end

	// capture in the cycle after rd
	always_ff @(posedge clk)
	begin
		if (state == CTL_FETCH && !rx_rd)
			tx_data <= rx_data;
	end

	// byte arriving on a full rx fifo is lost, flag sticks until reset
	always_ff @(posedge clk)
	begin
		if (reset)
			overrun <= 1'b0;
		else if (rx_valid && rx_full)
			overrun <= 1'b1;
	end

endmodule

// File: design/uart_echo.sv
`timescale 1ns/1ps

module uart_echo
	import uart_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic rxd,
	input  logic cts_n,
	output logic txd,
	output logic frame_error,
	output logic overrun
);

	logic                 tick;
	logic [DATA_BITS-1:0] rx_byte;
	logic                 rx_valid;
	logic                 frame_err;
	logic                 rx_rd;
	logic [DATA_BITS-1:0] rx_data;
	logic                 rx_empty;
	logic                 rx_full;
	logic                 tx_wr;
	logic [DATA_BITS-1:0] tx_data;
	logic                 tx_rd;
	logic [DATA_BITS-1:0] tx_fifo_data;
	logic                 tx_empty;
	logic                 tx_full;

	// shared 16x tick for both directions
	baud_tick_gen i_baud_tick_gen (
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	//////////////////////////////////////////////////
	// receive side
	//////////////////////////////////////////////////
	uart_receiver i_uart_receiver (
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.rxd       (rxd),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.frame_err (frame_err)
	);

	byte_fifo rx_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr      (rx_valid),
		.wr_data (rx_byte),
		.rd      (rx_rd),
		.rd_data (rx_data),
		.empty   (rx_empty),
		.full    (rx_full)
	);

	// moves one byte at a time between the fifos
	echo_controller i_echo_controller (
		.clk      (clk),
		.reset    (reset),
		.rx_empty (rx_empty),
		.rx_full  (rx_full),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.tx_full  (tx_full),
		.rx_rd    (rx_rd),
		.tx_wr    (tx_wr),
		.tx_data  (tx_data),
		.overrun  (overrun)
	);

	//////////////////////////////////////////////////
	// transmit side
	//////////////////////////////////////////////////
	byte_fifo tx_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr      (tx_wr),
		.wr_data (tx_data),
		.rd      (tx_rd),
		.rd_data (tx_fifo_data),
		.empty   (tx_empty),
		.full    (tx_full)
	);

	uart_transmitter i_uart_transmitter (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.cts_n      (cts_n),
		.fifo_empty (tx_empty),
		.fifo_data  (tx_fifo_data),
		.fifo_rd    (tx_rd),
		.txd        (txd)
	);

	// sticky frame error, cleared by reset only
	always_ff @(posedge clk)
	begin
		if (reset)
			frame_error <= 1'b0;
		else if (frame_err)
			frame_error <= 1'b1;
	end

endmodule

// File: verification/uart_echo_checker.sv
`timescale 1ns/1ps

module uart_echo_checker
	import uart_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic txd,
	input logic frame_error,
	input logic overrun
);

	localparam int BIT_CLKS = OVERSAMPLE * CLKS_PER_TICK;

	// test context loaded by the testbench
	string                test_name = "none";
	logic [DATA_BITS-1:0] exp_q[$];
	logic                 exp_fe;
	logic                 exp_ov;
	int                   first_got = 0;
	int                   errs_at_begin = 0;
	int                   pass_cnt = 0;
	int                   fail_cnt = 0;

	// decoder side
	logic [DATA_BITS-1:0] got_q[$];
	logic [DATA_BITS-1:0] rx_char;
	int                   decode_errs = 0;

	//////////////////////////////////////////////////
	// txd decoder sampling at mid-bit
	//////////////////////////////////////////////////
	always
	begin
		@(posedge clk);
		if (!reset && txd === 1'b0)
		begin
			// start bit middle lies 15 clocks after the first low sample
			repeat (BIT_CLKS / 2 - 1) @(posedge clk);
			if (txd !== 1'b0)
			begin
				$display("%s: start bit on txd ended before its middle", test_name);
				decode_errs++;
			end
			else
			begin
				// lsb first
				for (int i = 0; i < DATA_BITS; i++)
				begin
					repeat (BIT_CLKS) @(posedge clk);
					rx_char[i] = txd;
				end
				repeat (BIT_CLKS) @(posedge clk);
				if (txd !== 1'b1)
				begin
					$display("%s: stop bit on txd was low", test_name);
					decode_errs++;
				end
				check_char(rx_char);
			end
		end
	end

	// in-order compare against the expected list
	task automatic check_char(input logic [DATA_BITS-1:0] c);
		int idx;
		idx = got_q.size() - first_got;
		got_q.push_back(c);
		if (idx >= exp_q.size())
		begin
			$display("%s: unexpected extra character 0x%02h on txd", test_name, c);
			decode_errs++;
		end
		else if (c !== exp_q[idx])
		begin
			$display("ERROR %s: character %0d expected 0x%02h actual 0x%02h",
				test_name, idx, exp_q[idx], c);
			decode_errs++;
		end
	endtask

	//////////////////////////////////////////////////
	// test bookkeeping
	//////////////////////////////////////////////////
	task automatic begin_test(input string name, input logic fe, input logic ov);
		test_name = name;
		exp_fe = fe;
		exp_ov = ov;
		exp_q.delete();
		first_got = got_q.size();
		errs_at_begin = decode_errs;
	endtask

	task automatic expect_byte(input logic [DATA_BITS-1:0] b);
		exp_q.push_back(b);
	endtask

	// characters seen since begin_test
	function automatic int received();
		return got_q.size() - first_got;
	endfunction

	task automatic end_test();
		int errs;
		int got;
		got = got_q.size() - first_got;
		errs = decode_errs - errs_at_begin;
		if (got < exp_q.size())
		begin
			$display("%s: only %0d of %0d expected characters came back on txd",
				test_name, got, exp_q.size());
			errs++;
		end
		// line back at idle
		if (txd !== 1'b1)
		begin
			$display("ERROR %s: txd expected 1 actual %0b", test_name, txd);
			errs++;
		end
		// sticky flags
		if (frame_error !== exp_fe)
		begin
			$display("ERROR %s: frame_error expected %0b actual %0b",
				test_name, exp_fe, frame_error);
			errs++;
		end
		if (overrun !== exp_ov)
		begin
			$display("ERROR %s: overrun expected %0b actual %0b", test_name, exp_ov, overrun);
			errs++;
		end
		if (errs == 0)
		begin
			pass_cnt++;
			$display("PASS %s (%0d characters echoed)", test_name, got);
		end
		else
		begin
			fail_cnt++;
			$display("FAIL %s (%0d problems)", test_name, errs);
		end
	endtask

	task automatic report_counts();
		$display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
	endtask

endmodule

// File: verification/uart_echo_tb.sv
`timescale 1ns/1ps

module uart_echo_tb
	import uart_pkg::*;
();

	localparam int BIT_CLKS   = OVERSAMPLE * CLKS_PER_TICK;
	localparam int QUIET_CLKS = 400;
	localparam int MAX_GAP    = 40;

	logic clk;
	logic reset;
	logic rxd;
	logic cts_n;
	logic txd;
	logic frame_error;
	logic overrun;

	// pattern file contents with one entry per test
	string      names[$];
	int         cts_hold[$];
	int         exp_fe[$];
	int         exp_ov[$];
	int         send_first[$];
	int         send_num[$];
	int         exp_first[$];
	int         exp_num[$];
	logic [8:0] send_words[$];
	logic [7:0] exp_bytes[$];

	int seed = 32'h707f_9555;
	int cycles = 0;
	int cycle_limit = 0;

	initial clk = 1'b0;
	always #4 clk = ~clk;

	uart_echo i_uart_echo (
		.clk         (clk),
		.reset       (reset),
		.rxd         (rxd),
		.cts_n       (cts_n),
		.txd         (txd),
		.frame_error (frame_error),
		.overrun     (overrun)
	);

	uart_echo_checker i_checker (
		.clk         (clk),
		.reset       (reset),
		.txd         (txd),
		.frame_error (frame_error),
		.overrun     (overrun)
	);

	// run limit armed once the pattern file is loaded
	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////
	// inputs change 1 ns after the rising edge
	task automatic wait_clocks(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		rxd = 1'b1;
		cts_n = 1'b0;
		wait_clocks(16);
		reset = 1'b0;
	endtask

	// bit 8 of w is the stop bit put on the line
	task automatic send_char(input logic [8:0] w);
		rxd = 1'b0;
		wait_clocks(BIT_CLKS);
		for (int i = 0; i < 8; i++)
		begin
			rxd = w[i];
			wait_clocks(BIT_CLKS);
		end
		rxd = w[8];
		wait_clocks(BIT_CLKS);
		rxd = 1'b1;
		// a low stop bit needs one idle bit before the next start
		if (!w[8])
			wait_clocks(BIT_CLKS);
	endtask

	task automatic load_patterns(input int fd);
		string            tok;
		string            name;
		logic [8*256-1:0] skip;
		logic [8:0]       w;
		int               n;
		int               a;
		int               b;
		int               c;
		while ($fscanf(fd, "%s", tok) == 1)
		begin
			if (tok.substr(0, 0) == "#")
				n = $fgets(skip, fd);
			else if (tok == "test")
			begin
				n = $fscanf(fd, "%s %d %d %d", name, a, b, c);
				names.push_back(name);
				cts_hold.push_back(a);
				exp_fe.push_back(b);
				exp_ov.push_back(c);
			end
			else if (tok == "send")
			begin
				n = $fscanf(fd, "%d", a);
				send_first.push_back(send_words.size());
				send_num.push_back(a);
				repeat (a)
				begin
					n = $fscanf(fd, "%h", w);
					send_words.push_back(w);
				end
			end
			else if (tok == "expect")
			begin
				n = $fscanf(fd, "%d", a);
				exp_first.push_back(exp_bytes.size());
				exp_num.push_back(a);
				repeat (a)
				begin
					n = $fscanf(fd, "%h", w);
					exp_bytes.push_back(w[7:0]);
				end
			end
		end
	endtask

	task automatic run_test(input int t);
		int gap;
		int waited;
		apply_reset();
		i_checker.begin_test(names[t], exp_fe[t] != 0, exp_ov[t] != 0);
		for (int i = 0; i < exp_num[t]; i++)
			i_checker.expect_byte(exp_bytes[exp_first[t] + i]);
		cts_n = (cts_hold[t] != 0);
		for (int i = 0; i < send_num[t]; i++)
		begin
			send_char(send_words[send_first[t] + i]);
			gap = $unsigned($random(seed)) % (MAX_GAP + 1);
			wait_clocks(gap);
		end
		// release flow control so held bytes drain
		cts_n = 1'b0;
		// one character time per expected byte plus one for latency
		waited = 0;
		while (i_checker.received() < exp_num[t] && waited < (exp_num[t] + 1) * 10 * BIT_CLKS)
		begin
			wait_clocks(1);
			waited++;
		end
		// catch any extra character
		wait_clocks(QUIET_CLKS);
		i_checker.end_test();
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial
	begin
		int fd;
		reset = 1'b1;
		rxd = 1'b1;
		cts_n = 1'b0;
		fd = $fopen("verification/uart_echo_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open verification/uart_echo_patterns.txt");
			$display("SOME TESTS FAILED");
			$finish;
		end
		else
		begin
			load_patterns(fd);
			$fclose(fd);
			// 10 bits of 32 clocks per character, doubled, plus slack
			cycle_limit = send_words.size() * BIT_CLKS * 10 * 2 + 2000;
			for (int t = 0; t < names.size(); t++)
				run_test(t);
			i_checker.report_counts();
			if (names.size() == 0)
				$display("the pattern file held no tests");
			if (i_checker.fail_cnt == 0 && names.size() > 0)
				$display("ALL TESTS PASSED");
			else
				$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule

// File: uart_echo.f
design/uart_pkg.sv
design/baud_tick_gen.sv
design/uart_receiver.sv
design/uart_transmitter.sv
design/byte_fifo.sv
design/echo_controller.sv
design/uart_echo.sv
verification/uart_echo_checker.sv
verification/uart_echo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the uart_echo testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f uart_echo.f \
	--top-module uart_echo_tb \
	-o uart_echo_sim

output="$(./obj_dir/uart_echo_sim)"
echo "$output"

# the testbench prints the pass line only when every test passed
if echo "$output" | grep -qx "ALL TESTS PASSED"; then
	exit 0
else
	echo "run_sim.sh: simulation reported a failure"
	exit 1
fi

// File: verification/uart_echo_patterns.txt
# test   <name> <cts_n held high while sending> <expected frame_error> <expected overrun>
# send   <count> then 9-bit hex words, bit 8 is the stop bit sent (0 gives a framing error)
# expect <count> then the bytes that must come back on txd, in order

test reset_idle 0 0 0
send 0
expect 0

test single_byte 0 0 0
send 1 1a5
expect 1 a5

test burst_of_eight 0 0 0
send 8 100 1ff 155 1aa 101 180 17e 1e7
expect 8 00 ff 55 aa 01 80 7e e7

test bad_stop_bit 0 1 0
send 3 131 0c3 132
expect 2 31 32

test cts_overrun 1 0 1
send 18 1c0 1c1 1c2 1c3 1c4 1c5 1c6 1c7 1c8 1c9 1ca 1cb 1cc 1cd 1ce 1cf 1d0 1d1
expect 17 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf d0
